/* hw/tlb_pkg.sv */
// Shared widths and types of the address translation engine
// Small 4 KiB pages only, with a direct-mapped TLB
// Queue depths must stay powers of two so the pointers wrap by themselves
package tlb_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned VADDR_BITS   = 32;
    localparam int unsigned PADDR_BITS   = 32;
    localparam int unsigned PG_BITS      = 12;
    localparam int unsigned LEN_BITS     = 16;
    localparam int unsigned PID_BITS     = 4;
    localparam int unsigned TLB_IDX_BITS = 4;
    localparam int unsigned TAG_BITS     = VADDR_BITS - PG_BITS - TLB_IDX_BITS;
    localparam int unsigned PPN_BITS     = PADDR_BITS - PG_BITS;

    localparam int unsigned PG_SIZE     = 1 << PG_BITS;
    localparam int unsigned TLB_ENTRIES = 1 << TLB_IDX_BITS;

    // ------------------------------------------------------------------
    // Queue sizes
    // ------------------------------------------------------------------
    localparam int unsigned N_OUTSTANDING   = 8;
    localparam int unsigned REQ_QUEUE_DEPTH = 4;

    localparam int unsigned Q_PTR_BITS   = $clog2(REQ_QUEUE_DEPTH);
    localparam int unsigned Q_CNT_BITS   = $clog2(REQ_QUEUE_DEPTH + 1);
    localparam int unsigned OUT_PTR_BITS = $clog2(N_OUTSTANDING);
    localparam int unsigned OUT_CNT_BITS = $clog2(N_OUTSTANDING + 1);

    // Vector types
    typedef logic [VADDR_BITS-1:0]   vaddr_t;
    typedef logic [PADDR_BITS-1:0]   paddr_t;
    typedef logic [LEN_BITS-1:0]     len_t;
    typedef logic [PID_BITS-1:0]     pid_t;
    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [TLB_IDX_BITS-1:0] idx_t;
    typedef logic [PPN_BITS-1:0]     ppn_t;

endpackage

/* hw/tlb_if.sv */
// Internal handshake bundles of the translation engine
// All transfers complete on a cycle where valid and ready are both high
`timescale 1ns/1ps

// Queued request towards the FSM
interface xlat_req_if;
    import tlb_pkg::*;

    logic   valid;
    logic   ready;
    vaddr_t vaddr;
    len_t   len;
    pid_t   pid;
    logic   last;

    modport src (output valid, vaddr, len, pid, last, input ready);
    modport dst (input valid, vaddr, len, pid, last, output ready);
endinterface

// TLB probe, answer arrives one cycle after lookup_valid
interface tlb_lookup_if;
    import tlb_pkg::*;

    logic   lookup_valid;
    vaddr_t vaddr;
    pid_t   pid;
    logic   hit;
    ppn_t   ppn;

    modport fsm (output lookup_valid, vaddr, pid, input hit, ppn);
    modport tbl (input lookup_valid, vaddr, pid, output hit, ppn);
endinterface

// One DMA command per page fragment
interface dma_cmd_if;
    import tlb_pkg::*;

    logic   valid;
    logic   ready;
    paddr_t paddr;
    len_t   len;
    pid_t   pid;
    logic   last;

    modport src (output valid, paddr, len, pid, last, input ready);
    modport dst (input valid, paddr, len, pid, last, output ready);
endinterface

/* hw/req_queue.sv */
// Request FIFO in front of the translation FSM
// A pushed entry is offered on the output from the next cycle
// in_ready drops only while all REQ_QUEUE_DEPTH slots are taken
`timescale 1ns/1ps

module req_queue (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            in_valid,
    output logic            in_ready,
    input  tlb_pkg::vaddr_t in_vaddr,
    input  tlb_pkg::len_t   in_len,
    input  tlb_pkg::pid_t   in_pid,
    input  logic            in_last,
    xlat_req_if.src         out
);
    import tlb_pkg::*;

    vaddr_t vaddr_mem [REQ_QUEUE_DEPTH];
    len_t   len_mem   [REQ_QUEUE_DEPTH];
    pid_t   pid_mem   [REQ_QUEUE_DEPTH];
    logic   last_mem  [REQ_QUEUE_DEPTH];

    logic [Q_PTR_BITS-1:0] wr_ptr;
    logic [Q_PTR_BITS-1:0] rd_ptr;
    logic [Q_CNT_BITS-1:0] count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != Q_CNT_BITS'(REQ_QUEUE_DEPTH));
    assign push      = in_valid && in_ready;
    assign out.valid = (count != '0);
    assign pop       = out.valid && out.ready;

    // Head entry goes straight out
    assign out.vaddr = vaddr_mem[rd_ptr];
    assign out.len   = len_mem[rd_ptr];
    assign out.pid   = pid_mem[rd_ptr];
    assign out.last  = last_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + Q_PTR_BITS'(push);
            rd_ptr <= rd_ptr + Q_PTR_BITS'(pop);
            count  <= count + Q_CNT_BITS'(push) - Q_CNT_BITS'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            vaddr_mem[wr_ptr] <= in_vaddr;
            len_mem[wr_ptr]   <= in_len;
            pid_mem[wr_ptr]   <= in_pid;
            last_mem[wr_ptr]  <= in_last;
        end
    end

endmodule

/* hw/tlb_table.sv */
// Direct-mapped TLB for small pages
// A write lands on the next edge and a lookup in the same cycle sees the old entry
// hit and ppn are valid exactly one cycle after lookup_valid
`timescale 1ns/1ps

module tlb_table (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            wr_en,
    input  tlb_pkg::vaddr_t wr_vaddr,
    input  tlb_pkg::pid_t   wr_pid,
    input  tlb_pkg::ppn_t   wr_ppn,
    tlb_lookup_if.tbl       lup
);
    import tlb_pkg::*;

    logic [TLB_ENTRIES-1:0] entry_valid;
    tag_t                   tag_mem [TLB_ENTRIES];
    pid_t                   pid_mem [TLB_ENTRIES];
    ppn_t                   ppn_mem [TLB_ENTRIES];

    idx_t wr_idx;
    tag_t wr_tag;
    idx_t rd_idx;
    tag_t rd_tag;

    // Index sits right above the page offset, tag takes the rest
    assign wr_idx = wr_vaddr[PG_BITS +: TLB_IDX_BITS];
    assign wr_tag = wr_vaddr[PG_BITS+TLB_IDX_BITS +: TAG_BITS];
    assign rd_idx = lup.vaddr[PG_BITS +: TLB_IDX_BITS];
    assign rd_tag = lup.vaddr[PG_BITS+TLB_IDX_BITS +: TAG_BITS];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            entry_valid <= '0;
            lup.hit     <= 1'b0;
        end else begin
            if (wr_en) begin
                entry_valid[wr_idx] <= 1'b1;
            end
            // Tag and pid must both match
            lup.hit <= lup.lookup_valid && entry_valid[rd_idx] &&
                       (tag_mem[rd_idx] == rd_tag) && (pid_mem[rd_idx] == lup.pid);
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            tag_mem[wr_idx] <= wr_tag;
            pid_mem[wr_idx] <= wr_pid;
            ppn_mem[wr_idx] <= wr_ppn;
        end
        if (lup.lookup_valid) begin
            lup.ppn <= ppn_mem[rd_idx];
        end
    end

endmodule

/* hw/xlat_fsm.sv */
// Translation FSM, one request at a time
// Splits a transfer at 4 KiB boundaries with one TLB lookup per fragment
// A miss raises a page fault and waits for retry or drop
// Zero-length requests are taken and discarded
`timescale 1ns/1ps

module xlat_fsm (
    input  logic            aclk,
    input  logic            aresetn,
    xlat_req_if.dst         req,
    tlb_lookup_if.fsm       lup,
    dma_cmd_if.src          cmd,
    output logic            pf_valid,
    input  logic            pf_ready,
    output tlb_pkg::vaddr_t pf_vaddr,
    output tlb_pkg::len_t   pf_len,
    output tlb_pkg::pid_t   pf_pid,
    input  logic            pf_rsp_valid,
    output logic            pf_rsp_ready,
    input  logic            pf_rsp_retry
);
    import tlb_pkg::*;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, CHECK, CALC, SEND, FAULT, FAULT_WAIT
    } state_t;

    state_t state;
    state_t state_nxt;

    // Remaining part of the request
    vaddr_t vaddr_q;
    len_t   len_q;
    pid_t   pid_q;
    logic   last_q;

    // Current fragment
    ppn_t   ppn_q;
    len_t   page_rem_q;
    paddr_t paddr_q;
    len_t   frag_len_q;
    logic   frag_last_q;
    len_t   frag_len;

    assign frag_len = (len_q < page_rem_q) ? len_q : page_rem_q;

    // ------------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req.valid && (req.len != '0)) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: state_nxt = CHECK;
            CHECK:  state_nxt = lup.hit ? CALC : FAULT;
            CALC:   state_nxt = SEND;
            SEND: begin
                if (cmd.ready) begin
                    state_nxt = (len_q != '0) ? LOOKUP : IDLE;
                end
            end
            FAULT: begin
                if (pf_ready) begin
                    state_nxt = FAULT_WAIT;
                end
            end
            FAULT_WAIT: begin
                if (pf_rsp_valid) begin
                    state_nxt = pf_rsp_retry ? LOOKUP : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        case (state)
            IDLE: begin
                if (req.valid) begin
                    vaddr_q <= req.vaddr;
                    len_q   <= req.len;
                    pid_q   <= req.pid;
                    last_q  <= req.last;
                end
            end
            CHECK: begin
                ppn_q      <= lup.ppn;
                // Bytes left up to the page end
                page_rem_q <= len_t'(PG_SIZE) - len_t'(vaddr_q[PG_BITS-1:0]);
            end
            CALC: begin
                paddr_q     <= {ppn_q, vaddr_q[PG_BITS-1:0]};
                frag_len_q  <= frag_len;
                frag_last_q <= last_q && (frag_len == len_q);
                vaddr_q     <= vaddr_q + vaddr_t'(frag_len);
                len_q       <= len_q - frag_len;
            end
            default: ;
        endcase
    end

    // Handshakes follow the state directly
    assign req.ready        = (state == IDLE);
    assign lup.lookup_valid = (state == LOOKUP);
    assign lup.vaddr        = vaddr_q;
    assign lup.pid          = pid_q;

    assign cmd.valid = (state == SEND);
    assign cmd.paddr = paddr_q;
    assign cmd.len   = frag_len_q;
    assign cmd.pid   = pid_q;
    assign cmd.last  = frag_last_q;

    // Fault reports what is still left to move
    assign pf_valid     = (state == FAULT);
    assign pf_vaddr     = vaddr_q;
    assign pf_len       = len_q;
    assign pf_pid       = pid_q;
    assign pf_rsp_ready = (state == FAULT_WAIT);

endmodule

/* hw/dma_issue.sv */
// Host DMA command issue with an outstanding limit
// Commands pass through without a register while fewer than N_OUTSTANDING are open
// Completions return in issue order, one dma_done per command
`timescale 1ns/1ps

module dma_issue (
    input  logic            aclk,
    input  logic            aresetn,
    dma_cmd_if.dst          cmd,
    output logic            dma_req_valid,
    input  logic            dma_req_ready,
    output tlb_pkg::paddr_t dma_req_paddr,
    output tlb_pkg::len_t   dma_req_len,
    output logic            dma_req_last,
    input  logic            dma_done,
    output logic            done_valid,
    output tlb_pkg::pid_t   done_pid
);
    import tlb_pkg::*;

    // Completion queue holds pid and last of every open command
    pid_t cq_pid  [N_OUTSTANDING];
    logic cq_last [N_OUTSTANDING];

    logic [OUT_PTR_BITS-1:0] head;
    logic [OUT_PTR_BITS-1:0] tail;
    logic [OUT_CNT_BITS-1:0] out_cnt;
    logic                    can_issue;
    logic                    issue;

    assign can_issue = (out_cnt < OUT_CNT_BITS'(N_OUTSTANDING));
    assign cmd.ready = dma_req_ready && can_issue;
    assign issue     = cmd.valid && cmd.ready;

    assign dma_req_valid = cmd.valid && can_issue;
    assign dma_req_paddr = cmd.paddr;
    assign dma_req_len   = cmd.len;
    assign dma_req_last  = cmd.last;

    // Done only for the fragment that closes a last request
    assign done_valid = dma_done && cq_last[tail];
    assign done_pid   = cq_pid[tail];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            head    <= '0;
            tail    <= '0;
            out_cnt <= '0;
        end else begin
            head    <= head + OUT_PTR_BITS'(issue);
            tail    <= tail + OUT_PTR_BITS'(dma_done);
            out_cnt <= out_cnt + OUT_CNT_BITS'(issue) - OUT_CNT_BITS'(dma_done);
        end
    end

    always_ff @(posedge aclk) begin
        if (issue) begin
            cq_pid[head]  <= cmd.pid;
            cq_last[head] <= cmd.last;
        end
    end

endmodule

/* hw/tlb_xlat_top.sv */
// Address translation engine for a single host DMA channel
// done_valid is a one-cycle pulse with no back-pressure
`timescale 1ns/1ps

module tlb_xlat_top (
    input  logic            aclk,
    input  logic            aresetn,
    // Requests
    input  logic            req_valid,
    output logic            req_ready,
    input  tlb_pkg::vaddr_t req_vaddr,
    input  tlb_pkg::len_t   req_len,
    input  tlb_pkg::pid_t   req_pid,
    input  logic            req_last,
    // TLB write port
    input  logic            tlb_wr_en,
    input  tlb_pkg::vaddr_t tlb_wr_vaddr,
    input  tlb_pkg::pid_t   tlb_wr_pid,
    input  tlb_pkg::ppn_t   tlb_wr_ppn,
    // Page fault and its response
    output logic            pf_valid,
    input  logic            pf_ready,
    output tlb_pkg::vaddr_t pf_vaddr,
    output tlb_pkg::len_t   pf_len,
    output tlb_pkg::pid_t   pf_pid,
    input  logic            pf_rsp_valid,
    output logic            pf_rsp_ready,
    input  logic            pf_rsp_retry,
    // Host DMA
    output logic            dma_req_valid,
    input  logic            dma_req_ready,
    output tlb_pkg::paddr_t dma_req_paddr,
    output tlb_pkg::len_t   dma_req_len,
    output logic            dma_req_last,
    input  logic            dma_done,
    output logic            done_valid,
    output tlb_pkg::pid_t   done_pid
);

    xlat_req_if   req_if ();
    tlb_lookup_if lup_if ();
    dma_cmd_if    cmd_if ();

    req_queue i_req_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_vaddr (req_vaddr),
        .in_len   (req_len),
        .in_pid   (req_pid),
        .in_last  (req_last),
        .out      (req_if.src)
    );

    tlb_table i_tlb_table (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_en    (tlb_wr_en),
        .wr_vaddr (tlb_wr_vaddr),
        .wr_pid   (tlb_wr_pid),
        .wr_ppn   (tlb_wr_ppn),
        .lup      (lup_if.tbl)
    );

    xlat_fsm i_xlat_fsm (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .req          (req_if.dst),
        .lup          (lup_if.fsm),
        .cmd          (cmd_if.src),
        .pf_valid     (pf_valid),
        .pf_ready     (pf_ready),
        .pf_vaddr     (pf_vaddr),
        .pf_len       (pf_len),
        .pf_pid       (pf_pid),
        .pf_rsp_valid (pf_rsp_valid),
        .pf_rsp_ready (pf_rsp_ready),
        .pf_rsp_retry (pf_rsp_retry)
    );

    dma_issue i_dma_issue (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cmd           (cmd_if.dst),
        .dma_req_valid (dma_req_valid),
        .dma_req_ready (dma_req_ready),
        .dma_req_paddr (dma_req_paddr),
        .dma_req_len   (dma_req_len),
        .dma_req_last  (dma_req_last),
        .dma_done      (dma_done),
        .done_valid    (done_valid),
        .done_pid      (done_pid)
    );

endmodule

/* include/tb_checks.svh */
// Compare helpers for the testbench, included inside the testbench module
// Needs tlb_pkg compiled before the testbench
// The first mismatch stops the run
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic report_fail(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
endtask

task automatic check_paddr(input tlb_pkg::paddr_t got, input tlb_pkg::paddr_t exp,
                           input string what);
    if (got !== exp) begin
        report_fail($sformatf("%s paddr got %h expected %h", what, got, exp));
    end
endtask

task automatic check_len(input tlb_pkg::len_t got, input tlb_pkg::len_t exp,
                         input string what);
    if (got !== exp) begin
        report_fail($sformatf("%s len got %0d expected %0d", what, got, exp));
    end
endtask

task automatic check_pid(input tlb_pkg::pid_t got, input tlb_pkg::pid_t exp,
                         input string what);
    if (got !== exp) begin
        report_fail($sformatf("%s pid got %0d expected %0d", what, got, exp));
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_fail($sformatf("%s got %b expected %b", what, got, exp));
    end
endtask

// End of a clean run
task automatic report_pass();
    $display("NO ERRORS");
endtask

`endif

/* tests/tb_tlb_xlat.sv */
// Directed testbench of the translation engine
// The host model completes DMA commands in order after a random delay
// TLB entries map each virtual page to a ppn derived from the whole page number
`timescale 1ns/1ps

module tb_tlb_xlat;
    import tlb_pkg::*;

    localparam int CLK_PERIOD        = 10;
    localparam int N_RANDOM          = 40;
    localparam int DIRECT_CYCLES     = 800;
    localparam int CYCLES_PER_RANDOM = 80;
    localparam int TEST_CYCLES       = DIRECT_CYCLES + N_RANDOM * CYCLES_PER_RANDOM;
    localparam int WATCHDOG_MARGIN   = 3;
    localparam int WATCHDOG_NS       = TEST_CYCLES * CLK_PERIOD * WATCHDOG_MARGIN;
    localparam int DRAIN_LIMIT       = 2000;
    localparam int RAND_SEED         = 32'haffa_6312;

    logic   aclk;
    logic   aresetn;
    logic   req_valid;
    logic   req_ready;
    vaddr_t req_vaddr;
    len_t   req_len;
    pid_t   req_pid;
    logic   req_last;
    logic   tlb_wr_en;
    vaddr_t tlb_wr_vaddr;
    pid_t   tlb_wr_pid;
    ppn_t   tlb_wr_ppn;
    logic   pf_valid;
    logic   pf_ready;
    vaddr_t pf_vaddr;
    len_t   pf_len;
    pid_t   pf_pid;
    logic   pf_rsp_valid;
    logic   pf_rsp_ready;
    logic   pf_rsp_retry;
    logic   dma_req_valid;
    logic   dma_req_ready;
    paddr_t dma_req_paddr;
    len_t   dma_req_len;
    logic   dma_req_last;
    logic   dma_done;
    logic   done_valid;
    pid_t   done_pid;

    // Expected results, in arrival order
    paddr_t exp_paddr_q [$];
    len_t   exp_len_q   [$];
    logic   exp_last_q  [$];
    pid_t   exp_done_q  [$];

    int   open_cmds;
    int   done_gap;
    logic rand_ready;

    `include "tb_checks.svh"

    tlb_xlat_top i_tlb_xlat_top (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        report_fail("watchdog expired before the tests finished");
    end

    task automatic check_vaddr(input vaddr_t got, input vaddr_t exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s vaddr got %h expected %h", what, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // Host model and output monitor
    // ------------------------------------------------------------------
    always @(posedge aclk) begin
        if (rand_ready) begin
            dma_req_ready <= 1'($urandom_range(0, 1));
        end else begin
            dma_req_ready <= 1'b1;
        end
    end

    // Completes the oldest open command, never more than are open
    always @(posedge aclk) begin
        if (!aresetn) begin
            dma_done <= 1'b0;
            open_cmds = 0;
            done_gap  = 0;
        end else begin
            open_cmds = open_cmds + int'(dma_req_valid && dma_req_ready) - int'(dma_done);
            if (open_cmds > N_OUTSTANDING) begin
                report_fail("more DMA commands in flight than the outstanding limit");
            end
            if (done_gap > 0) begin
                done_gap = done_gap - 1;
                dma_done <= 1'b0;
            end else if (open_cmds > 0) begin
                dma_done <= 1'b1;
                done_gap = $urandom_range(0, 12);
            end else begin
                dma_done <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin
        if (aresetn && dma_req_valid && dma_req_ready) begin
            if (exp_paddr_q.size() == 0) begin
                report_fail("DMA command issued while none was expected");
            end else begin
                check_paddr(dma_req_paddr, exp_paddr_q.pop_front(), "command");
                check_len(dma_req_len, exp_len_q.pop_front(), "command");
                check_bit(dma_req_last, exp_last_q.pop_front(), "command last");
            end
        end
        if (aresetn && done_valid) begin
            if (exp_done_q.size() == 0) begin
                report_fail("done pulse seen while none was expected");
            end else begin
                // Same cycle as the completion that closes the request
                check_bit(dma_done, 1'b1, "done with dma_done");
                check_pid(done_pid, exp_done_q.pop_front(), "done");
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic ppn_t page_ppn(input vaddr_t va);
        return ppn_t'(va[VADDR_BITS-1:PG_BITS]) ^ ppn_t'(20'h3_c5a9);
    endfunction

    // Fragments end at each page boundary, only the final one carries last
    task automatic expect_request(input vaddr_t va, input len_t len, input pid_t pid,
                                  input logic last);
        vaddr_t addr;
        int     left;
        int     room;
        int     frag;
        addr = va;
        left = int'(len);
        while (left > 0) begin
            room = int'(PG_SIZE) - int'(addr[PG_BITS-1:0]);
            frag = (left < room) ? left : room;
            exp_paddr_q.push_back({page_ppn(addr), addr[PG_BITS-1:0]});
            exp_len_q.push_back(len_t'(frag));
            exp_last_q.push_back(last && (frag == left));
            addr = addr + vaddr_t'(frag);
            left = left - frag;
        end
        if (last && (len != '0)) begin
            exp_done_q.push_back(pid);
        end
    endtask

    task automatic tlb_write(input vaddr_t va, input pid_t pid);
        @(posedge aclk);
        tlb_wr_en    <= 1'b1;
        tlb_wr_vaddr <= va;
        tlb_wr_pid   <= pid;
        tlb_wr_ppn   <= page_ppn(va);
        @(posedge aclk);
        tlb_wr_en <= 1'b0;
    endtask

    task automatic send_req(input vaddr_t va, input len_t len, input pid_t pid,
                            input logic last);
        @(posedge aclk);
        req_valid <= 1'b1;
        req_vaddr <= va;
        req_len   <= len;
        req_pid   <= pid;
        req_last  <= last;
        @(posedge aclk);
        while (!req_ready) @(posedge aclk);
        req_valid <= 1'b0;
    endtask

    task automatic take_fault(input vaddr_t va, input len_t len, input pid_t pid);
        @(posedge aclk);
        while (!pf_valid) @(posedge aclk);
        check_vaddr(pf_vaddr, va, "fault");
        check_len(pf_len, len, "fault");
        check_pid(pf_pid, pid, "fault");
        // Held while pf_ready stays low
        repeat (3) @(posedge aclk);
        check_bit(pf_valid, 1'b1, "fault held");
        check_vaddr(pf_vaddr, va, "fault held");
        pf_ready <= 1'b1;
        @(posedge aclk);
        pf_ready <= 1'b0;
    endtask

    task automatic answer_fault(input logic retry);
        @(posedge aclk);
        pf_rsp_valid <= 1'b1;
        pf_rsp_retry <= retry;
        @(posedge aclk);
        while (!pf_rsp_ready) @(posedge aclk);
        pf_rsp_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_paddr_q.size() != 0) || (exp_done_q.size() != 0) || (open_cmds != 0)) begin
            @(posedge aclk);
            cycles = cycles + 1;
            if (cycles > DRAIN_LIMIT) begin
                report_fail("expected DMA commands or done pulses never arrived");
            end
        end
        repeat (20) @(posedge aclk);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic single_page_hit();
        $display("test: single page hit");
        tlb_write(32'h0001_2000, 4'd3);
        expect_request(32'h0001_2340, 16'd256, 4'd3, 1'b1);
        send_req(32'h0001_2340, 16'd256, 4'd3, 1'b1);
        wait_drain();
    endtask

    task automatic page_split();
        $display("test: page split");
        tlb_write(32'h0002_3000, 4'd5);
        tlb_write(32'h0002_4000, 4'd5);
        tlb_write(32'h0002_5000, 4'd5);
        tlb_write(32'h0003_6000, 4'd5);
        tlb_write(32'h0003_7000, 4'd5);
        expect_request(32'h0002_3f00, 16'd4480, 4'd5, 1'b1);
        send_req(32'h0002_3f00, 16'd4480, 4'd5, 1'b1);
        // Not last, so no done
        expect_request(32'h0003_6ff0, 16'd64, 4'd5, 1'b0);
        send_req(32'h0003_6ff0, 16'd64, 4'd5, 1'b0);
        wait_drain();
    endtask

    task automatic miss_and_retry();
        $display("test: miss and retry");
        expect_request(32'h0005_8800, 16'd4096, 4'd9, 1'b1);
        send_req(32'h0005_8800, 16'd4096, 4'd9, 1'b1);
        take_fault(32'h0005_8800, 16'd4096, 4'd9);
        tlb_write(32'h0005_8000, 4'd9);
        tlb_write(32'h0005_9000, 4'd9);
        answer_fault(1'b1);
        wait_drain();
    endtask

    task automatic drop_and_zero_length();
        $display("test: pid miss with drop, zero length");
        tlb_write(32'h0006_a000, 4'd1);
        send_req(32'h0006_a010, 16'd64, 4'd2, 1'b1);
        take_fault(32'h0006_a010, 16'd64, 4'd2);
        answer_fault(1'b0);
        repeat (30) @(posedge aclk);
        send_req(32'h0001_2000, 16'd0, 4'd3, 1'b1);
        expect_request(32'h0001_2ff8, 16'd8, 4'd3, 1'b1);
        send_req(32'h0001_2ff8, 16'd8, 4'd3, 1'b1);
        wait_drain();
    endtask

    // Pages 0 to 15 of one region fill every TLB index
    // Lower half belongs to pid 7, upper half to pid 12
    task automatic random_traffic();
        vaddr_t va;
        len_t   len;
        logic   last;
        int     half;
        pid_t   pid;
        $display("test: random back-pressure and ordering");
        for (int p = 0; p < TLB_ENTRIES; p++) begin
            tlb_write(32'h0040_0000 + vaddr_t'(p * PG_SIZE),
                      (p < TLB_ENTRIES / 2) ? 4'd7 : 4'd12);
        end
        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            half = int'($urandom_range(0, 1));
            pid  = (half == 0) ? 4'd7 : 4'd12;
            // Start page leaves room for three pages inside the half
            va   = 32'h0040_0000 + vaddr_t'((half * 8 + $urandom_range(0, 5)) * PG_SIZE)
                   + vaddr_t'($urandom_range(0, PG_SIZE - 1));
            len  = len_t'($urandom_range(0, 8192));
            last = 1'($urandom_range(0, 1));
            expect_request(va, len, pid, last);
            send_req(va, len, pid, last);
        end
        wait_drain();
        rand_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        aresetn      = 1'b0;
        req_valid    = 1'b0;
        req_vaddr    = '0;
        req_len      = '0;
        req_pid      = '0;
        req_last     = 1'b0;
        tlb_wr_en    = 1'b0;
        tlb_wr_vaddr = '0;
        tlb_wr_pid   = '0;
        tlb_wr_ppn   = '0;
        pf_ready     = 1'b0;
        pf_rsp_valid = 1'b0;
        pf_rsp_retry = 1'b0;
        dma_req_ready = 1'b0;
        dma_done     = 1'b0;
        rand_ready   = 1'b0;
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (2) @(posedge aclk);

        single_page_hit();
        page_split();
        miss_and_retry();
        drop_and_zero_length();
        random_traffic();

        if ((exp_paddr_q.size() != 0) || (exp_done_q.size() != 0)) begin
            report_fail("expected results were left over at the end of the run");
        end else begin
            report_pass();
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+include
hw/tlb_pkg.sv
hw/tlb_if.sv
hw/req_queue.sv
hw/tlb_table.sv
hw/xlat_fsm.sv
hw/dma_issue.sv
hw/tlb_xlat_top.sv
tests/tb_tlb_xlat.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --timing
TB_TOP     := tb_tlb_xlat
RTL_TOP    := tlb_xlat_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)

sim: build
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
